/* bench/fabric_clock.sv */
// ====================================================================
// Testbench clock and reset
// ====================================================================

module fabric_clock (
  output logic o_clk,
  output logic o_reset_n
);

  // Period of 10 time units
  initial
  begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Reset held for 16 cycles, released on a falling edge
  initial
  begin
    o_reset_n = 1'b0;
    repeat (16) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

/* bench/fabric_tb.sv */
// ====================================================================
// Memory fabric testbench
// ====================================================================

`include "fabric_defines.svh"

module fabric_tb;

  logic        clk;
  logic        reset_n;
  logic        debug_mode;
  logic        imem_rready;
  logic [31:0] imem_addr;
  logic        dmem_rready;
  logic        dmem_wvalid;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        pready = 1'b0;
  logic [31:0] prdata = '0;
  logic        pslverr = 1'b0;
  logic        o_imem_rvalid;
  logic [31:0] o_imem_rdata;
  logic        o_dmem_rvalid;
  logic [31:0] o_dmem_rdata;
  logic        o_dmem_wready;
  logic [12:0] o_apb_paddr;
  logic        o_apb_psel;
  logic        o_apb_penable;
  logic        o_apb_pwrite;
  logic [31:0] o_apb_pwdata;
  logic [31:0] o_tohost;

  // Reference RAM and expected debug memory
  logic [31:0] ref_mem [0:`FABRIC_RAM_WORDS-1];
  logic [31:0] dbg_exp [0:1023];
  // Responder-side debug memory
  logic [31:0] dbg_mem [0:1023];
  logic        dbg_written [0:1023] = '{default: 1'b0};
  int          wait_left = 0;
  int          err_count = 0;
  int          err_target = 0;
  // Responses sampled at the rising edge
  logic        imem_hit;
  logic        dmem_hit;
  logic        wr_hit;
  logic [31:0] imem_seen;
  logic [31:0] dmem_seen;
  // Expected APB transfer fields
  logic        apb_check = 1'b0;
  logic [12:0] exp_paddr = '0;
  logic        exp_pwrite = 1'b0;
  logic [31:0] exp_pwdata = '0;

  fabric_clock fabric_clock_inst (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  bus_fabric_top bus_fabric_top_inst (
    .clk (clk), .reset_n (reset_n), .i_debug_mode (debug_mode),
    .i_imem_rready (imem_rready), .i_imem_addr (imem_addr),
    .o_imem_rvalid (o_imem_rvalid), .o_imem_rdata (o_imem_rdata),
    .i_dmem_rready (dmem_rready), .i_dmem_wvalid (dmem_wvalid),
    .i_dmem_addr (dmem_addr), .i_dmem_wdata (dmem_wdata),
    .o_dmem_rvalid (o_dmem_rvalid), .o_dmem_rdata (o_dmem_rdata),
    .o_dmem_wready (o_dmem_wready),
    .o_apb_paddr (o_apb_paddr), .o_apb_psel (o_apb_psel),
    .o_apb_penable (o_apb_penable), .o_apb_pwrite (o_apb_pwrite),
    .o_apb_pwdata (o_apb_pwdata), .i_apb_pready (pready),
    .i_apb_prdata (prdata), .i_apb_pslverr (pslverr), .o_tohost (o_tohost)
  );

  task automatic check_fail(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out at time %0t while waiting for %s", $time, what);
    $display("test failed");
    $fatal(1, "stopped on timeout");
  endtask

  function automatic logic in_debug(input logic [31:0] addr);
    return (addr >= `FABRIC_DEBUG_START) && (addr <= `FABRIC_DEBUG_END);
  endfunction

  // RAM window 0x10000 to 0x13FFF or the all-ones alias
  function automatic logic in_ram(input logic [31:0] addr);
    return ((addr >= 32'h0001_0000) && (addr <= 32'h0001_3FFF)) || (&addr[31:14]);
  endfunction

  // Debug memory fill, unique per word address
  function automatic logic [31:0] dbg_fill(input logic [9:0] idx);
    return 32'hDB00_0000 | {20'h0, idx, 2'b00};
  endfunction

  always @(posedge clk)
  begin
    imem_hit  <= o_imem_rvalid;
    dmem_hit  <= o_dmem_rvalid;
    wr_hit    <= o_dmem_wready;
    imem_seen <= o_imem_rdata;
    dmem_seen <= o_dmem_rdata;
  end

  // ==================================================================
  // APB responder, 0 to 3 wait cycles and optional pslverr
  // ==================================================================
  always @(negedge clk)
  begin
    pready  <= 1'b0;
    pslverr <= 1'b0;
    if (o_apb_psel && !o_apb_penable)
      wait_left = $urandom % 4;
    else if (o_apb_psel && o_apb_penable)
    begin
      if (wait_left > 0)
        wait_left--;
      else if (err_count < err_target)
      begin
        pslverr <= 1'b1;
        err_count++;
      end
      else
      begin
        pready <= 1'b1;
        prdata <= dbg_written[o_apb_paddr[11:2]] ? dbg_mem[o_apb_paddr[11:2]]
                                                 : dbg_fill(o_apb_paddr[11:2]);
        if (o_apb_pwrite)
        begin
          dbg_mem[o_apb_paddr[11:2]]     <= o_apb_pwdata;
          dbg_written[o_apb_paddr[11:2]] <= 1'b1;
        end
      end
    end
  end

  // ==================================================================
  // Protocol and response assertions
  // ==================================================================
  a_enable_sel: assert property (@(posedge clk) disable iff (!reset_n)
    o_apb_penable |-> o_apb_psel) else check_fail("penable without psel");
  a_setup_first: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(o_apb_penable) |-> $past(o_apb_psel && !o_apb_penable))
    else check_fail("access phase without setup phase");
  a_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (o_apb_psel && o_apb_penable && !pready && !pslverr) |=> (o_apb_penable &&
    $stable(o_apb_paddr) && $stable(o_apb_pwrite) && $stable(o_apb_pwdata)))
    else check_fail("APB signals changed while pready low");
  a_fields: assert property (@(posedge clk) disable iff (!reset_n)
    (apb_check && o_apb_psel) |-> (o_apb_paddr == exp_paddr && o_apb_pwrite == exp_pwrite &&
    (!exp_pwrite || o_apb_pwdata == exp_pwdata)))
    else check_fail("wrong paddr, pwrite or pwdata");
  a_local_wready: assert property (@(posedge clk) disable iff (!reset_n)
    (dmem_wvalid && (in_ram(dmem_addr) || dmem_addr == `FABRIC_TOHOST_ADDR)) |->
    o_dmem_wready) else check_fail("RAM or tohost write not ready in its own cycle");
  a_wr_done: assert property (@(posedge clk) disable iff (!reset_n)
    (o_apb_penable && pready && o_apb_pwrite) |-> o_dmem_wready)
    else check_fail("debug write completed without wready");
  a_wr_only_done: assert property (@(posedge clk) disable iff (!reset_n)
    (debug_mode && dmem_wvalid && in_debug(dmem_addr) && o_dmem_wready) |->
    (o_apb_penable && pready)) else check_fail("debug wready outside completion");
  a_rd_done: assert property (@(posedge clk) disable iff (!reset_n)
    (o_apb_penable && pready && !o_apb_pwrite) |-> (o_dmem_rvalid || o_imem_rvalid))
    else check_fail("debug read completed without valid");
  a_err_silent: assert property (@(posedge clk) disable iff (!reset_n)
    (o_apb_penable && pslverr && !pready) |->
    (!o_dmem_rvalid && !o_imem_rvalid && !o_dmem_wready))
    else check_fail("response given for pslverr transfer");
  a_err_after: assert property (@(posedge clk) disable iff (!reset_n)
    (o_apb_penable && pslverr && !pready) |=>
    (!o_dmem_rvalid && !o_imem_rvalid && !o_dmem_wready))
    else check_fail("response given in the cycle after pslverr");
  a_no_dbg: assert property (@(posedge clk) disable iff (!reset_n)
    !debug_mode |-> !o_apb_psel) else check_fail("psel raised outside debug mode");
  a_tohost: assert property (@(posedge clk) disable iff (!reset_n)
    (dmem_wvalid && dmem_addr == `FABRIC_TOHOST_ADDR) |=> (o_tohost == $past(dmem_wdata)))
    else check_fail("tohost not updated");

  // Kind 0 is write readiness, 1 data read, 2 fetch
  task automatic wait_response(input int kind, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!((kind == 0) ? wr_hit : (kind == 1) ? dmem_hit : imem_hit))
    begin
      n++;
      if (n > 200)
        timeout_fail(what);
      @(negedge clk);
    end
  endtask

  task automatic data_write(input logic [31:0] addr, input logic [31:0] data);
    dmem_addr   = addr;
    dmem_wdata  = data;
    dmem_wvalid = 1'b1;
    wait_response(0, "write readiness");
    dmem_wvalid = 1'b0;
    @(negedge clk);
  endtask

  task automatic data_read(input logic [31:0] addr, output logic [31:0] got);
    dmem_addr   = addr;
    dmem_rready = 1'b1;
    wait_response(1, "data read valid");
    got         = dmem_seen;
    dmem_rready = 1'b0;
    @(negedge clk);
  endtask

  task automatic fetch(input logic [31:0] addr, output logic [31:0] got);
    imem_addr   = addr;
    imem_rready = 1'b1;
    wait_response(2, "fetch valid");
    got         = imem_seen;
    imem_rready = 1'b0;
    @(negedge clk);
  endtask

  // Random RAM address, half of them through the alias
  function automatic logic [31:0] ram_addr_of(input int k, input logic alias_sel);
    return alias_sel ? (32'hFFFF_C000 | {18'h0, k[11:0], 2'b00})
                     : (`FABRIC_RAM_BASE + {18'h0, k[11:0], 2'b00});
  endfunction

  initial
  begin
    int          seed;
    int          k;
    int          j;
    int          n;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] got;
    logic [31:0] got_f;
    seed        = $urandom(40623);
    debug_mode  = 1'b0;
    imem_rready = 1'b0;
    imem_addr   = '0;
    dmem_rready = 1'b0;
    dmem_wvalid = 1'b0;
    dmem_addr   = '0;
    dmem_wdata  = '0;
    for (k = 0; k < 1024; k++)
      dbg_exp[k] = dbg_fill(k[9:0]);
    n = 0;
    while (!reset_n)
    begin
      n++;
      if (n > 100)
        timeout_fail("reset release");
      @(negedge clk);
    end
    assert (!o_apb_psel && !o_apb_penable && !o_apb_pwrite && !o_imem_rvalid &&
            !o_dmem_rvalid && !o_dmem_wready && o_tohost == 32'h0)
      else check_fail("outputs not quiet after reset");

    // ================================================================
    // RAM fill, then read latency
    // ================================================================
    for (k = 0; k < `FABRIC_RAM_WORDS; k++)
    begin
      data = $urandom;
      data_write(ram_addr_of(k, 1'b0), data);
      ref_mem[k] = data;
    end
    dmem_addr   = ram_addr_of(77, 1'b0);
    dmem_rready = 1'b1;
    @(negedge clk);
    assert (!o_dmem_rvalid) else check_fail("read valid after one edge");
    @(negedge clk);
    assert (o_dmem_rvalid && o_dmem_rdata == ref_mem[77])
      else check_fail("read valid or data wrong two edges after issue");
    dmem_rready = 1'b0;
    @(negedge clk);

    // Random fetches and reads, normal and alias
    repeat (200)
    begin
      k    = $urandom % 4096;
      addr = ram_addr_of(k, $urandom % 2 == 0);
      if ($urandom % 2 == 0)
        fetch(addr, got);
      else
        data_read(addr, got);
      assert (got == ref_mem[k]) else check_fail("RAM read data mismatch");
    end

    // Fetch overlapped by data reads
    k = $urandom % 4096;
    fork
      begin
        fetch(ram_addr_of(k, 1'b0), got_f);
        assert (got_f == ref_mem[k]) else check_fail("overlapped fetch data mismatch");
      end
      begin
        repeat (6)
        begin
          j = $urandom % 4096;
          data_read(ram_addr_of(j, 1'b1), got);
          assert (got == ref_mem[j]) else check_fail("data read mismatch");
        end
      end
    join

    // ================================================================
    // Debug area over APB
    // ================================================================
    debug_mode = 1'b1;
    @(negedge clk);
    apb_check = 1'b1;
    repeat (12)
    begin
      addr       = 32'h200 + (($urandom % 896) * 4);
      data       = $urandom;
      exp_paddr  = addr[12:0];
      exp_pwrite = 1'b1;
      exp_pwdata = data;
      data_write(addr, data);
      dbg_exp[addr[11:2]] = data;
    end
    repeat (12)
    begin
      addr       = 32'h200 + (($urandom % 896) * 4);
      exp_paddr  = addr[12:0];
      exp_pwrite = 1'b0;
      if ($urandom % 2 == 0)
        fetch(addr, got);
      else
        data_read(addr, got);
      assert (got == dbg_exp[addr[11:2]]) else check_fail("debug read data mismatch");
    end
    // Injected pslverr, held request retries
    addr       = 32'h400;
    exp_paddr  = addr[12:0];
    err_target = err_count + 1;
    data_read(addr, got);
    assert (err_count == err_target) else check_fail("pslverr was not injected");
    assert (got == dbg_exp[addr[11:2]]) else check_fail("retried read data mismatch");
    apb_check  = 1'b0;

    // Debug area is unmapped outside debug mode
    debug_mode  = 1'b0;
    @(negedge clk);
    dmem_addr   = 32'h600;
    imem_addr   = 32'h800;
    dmem_rready = 1'b1;
    imem_rready = 1'b1;
    repeat (30)
    begin
      @(negedge clk);
      assert (!dmem_hit && !imem_hit) else check_fail("response outside debug mode");
    end
    dmem_rready = 1'b0;
    imem_rready = 1'b0;
    @(negedge clk);

    // ================================================================
    // Tohost write leaves RAM alone
    // ================================================================
    data = $urandom;
    data_write(`FABRIC_TOHOST_ADDR, data);
    assert (o_tohost == data) else check_fail("tohost value wrong");
    repeat (16)
    begin
      k = $urandom % 4096;
      data_read(ram_addr_of(k, 1'b0), got);
      assert (got == ref_mem[k]) else check_fail("RAM changed by tohost");
    end

    $display("test passed");
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
logic/fabric_pkg.sv
logic/region_decoder.sv
logic/shared_ram.sv
logic/debug_apb_bridge.sv
logic/response_merge.sv
logic/bus_fabric_top.sv
bench/fabric_clock.sv
bench/fabric_tb.sv

/* logic/bus_fabric_top.sv */
// ====================================================================
// Memory fabric top level
// ====================================================================

`include "fabric_defines.svh"

module bus_fabric_top (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      i_debug_mode,
  // Fetch port
  input  logic                      i_imem_rready,
  input  logic [`FABRIC_XLEN-1:0]   i_imem_addr,
  output logic                      o_imem_rvalid,
  output logic [`FABRIC_XLEN-1:0]   o_imem_rdata,
  // Data port
  input  logic                      i_dmem_rready,
  input  logic                      i_dmem_wvalid,
  input  logic [`FABRIC_XLEN-1:0]   i_dmem_addr,
  input  logic [`FABRIC_XLEN-1:0]   i_dmem_wdata,
  output logic                      o_dmem_rvalid,
  output logic [`FABRIC_XLEN-1:0]   o_dmem_rdata,
  output logic                      o_dmem_wready,
  // Debug module APB
  output logic [`FABRIC_APB_AW-1:0] o_apb_paddr,
  output logic                      o_apb_psel,
  output logic                      o_apb_penable,
  output logic                      o_apb_pwrite,
  output logic [`FABRIC_XLEN-1:0]   o_apb_pwdata,
  input  logic                      i_apb_pready,
  input  logic [`FABRIC_XLEN-1:0]   i_apb_prdata,
  input  logic                      i_apb_pslverr,
  output logic [`FABRIC_XLEN-1:0]   o_tohost
);

  import fabric_pkg::*;

  region_t                   imem_region;
  region_t                   dmem_region;
  logic [`FABRIC_RAM_AW-1:0] imem_word;
  logic [`FABRIC_RAM_AW-1:0] dmem_word;
  logic                      ram_imem_valid;
  logic [`FABRIC_XLEN-1:0]   ram_imem_data;
  logic                      ram_dmem_valid;
  logic [`FABRIC_XLEN-1:0]   ram_dmem_data;
  apb_state_t                apb_state;
  logic                      apb_for_imem;
  logic                      apb_is_write;

  // ==================================================================
  // Per-target request enables
  // ==================================================================
  logic ram_imem_rd;
  logic ram_dmem_rd;
  logic ram_dmem_wr;
  logic dbg_imem_req;
  logic dbg_dmem_rd;
  logic dbg_dmem_wr;

  assign ram_imem_rd  = i_imem_rready && (imem_region == REGION_RAM);
  assign ram_dmem_rd  = i_dmem_rready && (dmem_region == REGION_RAM);
  assign ram_dmem_wr  = i_dmem_wvalid && (dmem_region == REGION_RAM);
  assign dbg_imem_req = i_imem_rready && (imem_region == REGION_DEBUG);
  assign dbg_dmem_rd  = i_dmem_rready && (dmem_region == REGION_DEBUG);
  assign dbg_dmem_wr  = i_dmem_wvalid && (dmem_region == REGION_DEBUG);

  region_decoder region_decoder_inst (
    .i_imem_addr   (i_imem_addr),
    .i_dmem_addr   (i_dmem_addr),
    .i_debug_mode  (i_debug_mode),
    .o_imem_region (imem_region),
    .o_dmem_region (dmem_region),
    .o_imem_word   (imem_word),
    .o_dmem_word   (dmem_word)
  );

  shared_ram shared_ram_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_imem_rd    (ram_imem_rd),
    .i_dmem_rd    (ram_dmem_rd),
    .i_dmem_wr    (ram_dmem_wr),
    .i_imem_word  (imem_word),
    .i_dmem_word  (dmem_word),
    .i_dmem_wdata (i_dmem_wdata),
    .o_imem_valid (ram_imem_valid),
    .o_imem_data  (ram_imem_data),
    .o_dmem_valid (ram_dmem_valid),
    .o_dmem_data  (ram_dmem_data)
  );

  debug_apb_bridge debug_apb_bridge_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_imem_req    (dbg_imem_req),
    .i_dmem_rd     (dbg_dmem_rd),
    .i_dmem_wr     (dbg_dmem_wr),
    .i_imem_addr   (i_imem_addr),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wdata  (i_dmem_wdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .i_apb_pslverr (i_apb_pslverr),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .o_state       (apb_state),
    .o_for_imem    (apb_for_imem),
    .o_is_write    (apb_is_write)
  );

  response_merge response_merge_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .i_imem_region    (imem_region),
    .i_dmem_region    (dmem_region),
    .i_dmem_rd        (i_dmem_rready),
    .i_dmem_wr        (i_dmem_wvalid),
    .i_dmem_addr      (i_dmem_addr),
    .i_dmem_wdata     (i_dmem_wdata),
    .i_ram_imem_valid (ram_imem_valid),
    .i_ram_imem_data  (ram_imem_data),
    .i_ram_dmem_valid (ram_dmem_valid),
    .i_ram_dmem_data  (ram_dmem_data),
    .i_apb_state      (apb_state),
    .i_for_imem       (apb_for_imem),
    .i_is_write       (apb_is_write),
    .i_apb_pready     (i_apb_pready),
    .i_apb_prdata     (i_apb_prdata),
    .o_imem_rvalid    (o_imem_rvalid),
    .o_imem_rdata     (o_imem_rdata),
    .o_dmem_rvalid    (o_dmem_rvalid),
    .o_dmem_rdata     (o_dmem_rdata),
    .o_dmem_wready    (o_dmem_wready),
    .o_tohost         (o_tohost)
  );

endmodule

/* logic/debug_apb_bridge.sv */
// ====================================================================
// Debug area APB master
// ====================================================================

`include "fabric_defines.svh"

module debug_apb_bridge (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      i_debug_mode,
  input  logic                      i_imem_req,
  input  logic                      i_dmem_rd,
  input  logic                      i_dmem_wr,
  input  logic [`FABRIC_XLEN-1:0]   i_imem_addr,
  input  logic [`FABRIC_XLEN-1:0]   i_dmem_addr,
  input  logic [`FABRIC_XLEN-1:0]   i_dmem_wdata,
  input  logic                      i_apb_pready,
  input  logic [`FABRIC_XLEN-1:0]   i_apb_prdata,
  input  logic                      i_apb_pslverr,
  output logic [`FABRIC_APB_AW-1:0] o_apb_paddr,
  output logic                      o_apb_psel,
  output logic                      o_apb_penable,
  output logic                      o_apb_pwrite,
  output logic [`FABRIC_XLEN-1:0]   o_apb_pwdata,
  output fabric_pkg::apb_state_t    o_state,
  output logic                      o_for_imem,
  output logic                      o_is_write
);

  import fabric_pkg::*;

  apb_state_t                state;
  apb_state_t                state_nx;
  logic                      dmem_req;
  logic                      start;
  logic [`FABRIC_APB_AW-1:0] addr_q;
  logic [`FABRIC_XLEN-1:0]   wdata_q;
  logic                      write_q;
  logic                      for_imem_q;

  assign dmem_req = i_dmem_rd || i_dmem_wr;
  assign start    = (state == APB_IDLE) && (dmem_req || i_imem_req);

  // ==================================================================
  // Transfer FSM
  // ==================================================================
  always_comb
  begin
    state_nx = state;
    case (state)
      APB_IDLE:
        if (start)
          state_nx = APB_SETUP;
      APB_SETUP:
        state_nx = APB_ACCESS;
      APB_ACCESS:
        if (i_apb_pready)
          state_nx = APB_IDLE;
        else if (i_apb_pslverr)
          state_nx = APB_ERROR;
      // One dead cycle, requester retries by holding its level
      APB_ERROR:
        state_nx = APB_IDLE;
      default:
        state_nx = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state <= APB_IDLE;
    else if (!i_debug_mode)
      state <= APB_IDLE;
    else
      state <= state_nx;
  end

  // Direction and requester, data side first
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      write_q    <= 1'b0;
      for_imem_q <= 1'b0;
    end
    else if (start)
    begin
      write_q    <= i_dmem_wr;
      for_imem_q <= !dmem_req;
    end
  end

  // Transfer address and write data
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      addr_q  <= dmem_req ? i_dmem_addr[`FABRIC_APB_AW-1:0] : i_imem_addr[`FABRIC_APB_AW-1:0];
      wdata_q <= i_dmem_wdata;
    end
  end

  // ==================================================================
  // APB outputs decoded from state
  // ==================================================================
  assign o_apb_psel    = (state == APB_SETUP) || (state == APB_ACCESS);
  assign o_apb_penable = (state == APB_ACCESS);
  assign o_apb_paddr   = addr_q;
  assign o_apb_pwrite  = write_q;
  assign o_apb_pwdata  = wdata_q;
  assign o_state       = state;
  assign o_for_imem    = for_imem_q;
  assign o_is_write    = write_q;

endmodule

/* logic/fabric_defines.svh */
// ====================================================================
// Memory fabric address map
// ====================================================================

`ifndef FABRIC_DEFINES_SVH
`define FABRIC_DEFINES_SVH

// Core data and address width
`define FABRIC_XLEN 32

// Program RAM window, 16 KB of 32-bit words
`define FABRIC_RAM_BASE 32'h0001_0000
`define FABRIC_RAM_WORDS 4096
`define FABRIC_RAM_AW 12

// Upper field that marks the all-ones RAM alias
`define FABRIC_ALIAS_BITS 18

// Debug module area, visible only in debug mode
`define FABRIC_DEBUG_START 32'h0000_0200
`define FABRIC_DEBUG_END 32'h0000_0FFF

// Test result word
`define FABRIC_TOHOST_ADDR 32'h8000_1000

// APB address width toward the debug module
`define FABRIC_APB_AW 13

`endif

/* logic/fabric_pkg.sv */
// ====================================================================
// Memory fabric shared types
// ====================================================================

package fabric_pkg;

  // Target of a request address
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_RAM,
    REGION_DEBUG,
    REGION_TOHOST
  } region_t;

  // Owner of the single RAM port in a cycle
  typedef enum logic [1:0] {
    GRANT_IDLE,
    GRANT_DMEM_WR,
    GRANT_DMEM_RD,
    GRANT_IMEM_RD
  } ram_grant_t;

  // Debug bridge APB master states
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS,
    APB_ERROR
  } apb_state_t;

endpackage

/* logic/region_decoder.sv */
// ====================================================================
// Request address decoder
// ====================================================================

`include "fabric_defines.svh"

module region_decoder (
  input  logic [`FABRIC_XLEN-1:0]   i_imem_addr,
  input  logic [`FABRIC_XLEN-1:0]   i_dmem_addr,
  input  logic                      i_debug_mode,
  output fabric_pkg::region_t       o_imem_region,
  output fabric_pkg::region_t       o_dmem_region,
  output logic [`FABRIC_RAM_AW-1:0] o_imem_word,
  output logic [`FABRIC_RAM_AW-1:0] o_dmem_word
);

  import fabric_pkg::*;

  // Last byte of the RAM window, 0x13FFF
  localparam logic [`FABRIC_XLEN-1:0] RAM_END =
    `FABRIC_RAM_BASE + (`FABRIC_RAM_WORDS * 4) - 1;

  // Upper field all ones maps onto the RAM by its low bits
  function automatic logic is_alias(input logic [`FABRIC_XLEN-1:0] addr);
    return &addr[`FABRIC_XLEN-1 -: `FABRIC_ALIAS_BITS];
  endfunction

  function automatic region_t classify(input logic [`FABRIC_XLEN-1:0] addr,
                                       input logic                    dbg);
    region_t r;
    // Debug area shadows nothing else but only exists while halted
    if (dbg && (addr >= `FABRIC_DEBUG_START) && (addr <= `FABRIC_DEBUG_END))
      r = REGION_DEBUG;
    else if (((addr >= `FABRIC_RAM_BASE) && (addr <= RAM_END)) || is_alias(addr))
      r = REGION_RAM;
    else if (addr == `FABRIC_TOHOST_ADDR)
      r = REGION_TOHOST;
    else
      r = REGION_NONE;
    return r;
  endfunction

  function automatic logic [`FABRIC_RAM_AW-1:0] word_of(input logic [`FABRIC_XLEN-1:0] addr);
    logic [`FABRIC_XLEN-1:0] offset;
    // Alias keeps only the low 14 bits, otherwise offset from base
    if (is_alias(addr))
    begin
      offset = '0;
      offset[`FABRIC_RAM_AW+1:0] = addr[`FABRIC_RAM_AW+1:0];
    end
    else
      offset = addr - `FABRIC_RAM_BASE;
    return offset[`FABRIC_RAM_AW+1:2];
  endfunction

  // ==================================================================
  // Both ports decode in parallel
  // ==================================================================
  assign o_imem_region = classify(i_imem_addr, i_debug_mode);
  assign o_dmem_region = classify(i_dmem_addr, i_debug_mode);
  assign o_imem_word   = word_of(i_imem_addr);
  assign o_dmem_word   = word_of(i_dmem_addr);

endmodule

/* logic/response_merge.sv */
// ====================================================================
// Core response merge and tohost
// ====================================================================

`include "fabric_defines.svh"

module response_merge (
  input  logic                    clk,
  input  logic                    reset_n,
  input  fabric_pkg::region_t     i_imem_region,
  input  fabric_pkg::region_t     i_dmem_region,
  input  logic                    i_dmem_rd,
  input  logic                    i_dmem_wr,
  input  logic [`FABRIC_XLEN-1:0] i_dmem_addr,
  input  logic [`FABRIC_XLEN-1:0] i_dmem_wdata,
  input  logic                    i_ram_imem_valid,
  input  logic [`FABRIC_XLEN-1:0] i_ram_imem_data,
  input  logic                    i_ram_dmem_valid,
  input  logic [`FABRIC_XLEN-1:0] i_ram_dmem_data,
  input  fabric_pkg::apb_state_t  i_apb_state,
  input  logic                    i_for_imem,
  input  logic                    i_is_write,
  input  logic                    i_apb_pready,
  input  logic [`FABRIC_XLEN-1:0] i_apb_prdata,
  output logic                    o_imem_rvalid,
  output logic [`FABRIC_XLEN-1:0] o_imem_rdata,
  output logic                    o_dmem_rvalid,
  output logic [`FABRIC_XLEN-1:0] o_dmem_rdata,
  output logic                    o_dmem_wready,
  output logic [`FABRIC_XLEN-1:0] o_tohost
);

  import fabric_pkg::*;

  logic bridge_done;
  logic local_wr;

  // Completion is the first access cycle with pready
  assign bridge_done = (i_apb_state == APB_ACCESS) && i_apb_pready;

  // RAM and tohost accept a write in the cycle it is shown
  assign local_wr = i_dmem_wr &&
                    ((i_dmem_region == REGION_RAM) || (i_dmem_region == REGION_TOHOST));

  // ==================================================================
  // Valids and readiness
  // ==================================================================
  assign o_dmem_wready = local_wr || (bridge_done && !i_for_imem && i_is_write && i_dmem_wr);
  assign o_dmem_rvalid = i_ram_dmem_valid ||
                         (bridge_done && !i_for_imem && !i_is_write && i_dmem_rd);
  assign o_imem_rvalid = i_ram_imem_valid || (bridge_done && i_for_imem);

  // Debug reads pass prdata through in the pready cycle
  assign o_imem_rdata = (i_imem_region == REGION_DEBUG) ? i_apb_prdata : i_ram_imem_data;
  assign o_dmem_rdata = (i_dmem_region == REGION_DEBUG) ? i_apb_prdata : i_ram_dmem_data;

  // ==================================================================
  // Tohost register
  // ==================================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (i_dmem_wr && (i_dmem_addr == `FABRIC_TOHOST_ADDR))
      o_tohost <= i_dmem_wdata;
  end

endmodule

/* logic/shared_ram.sv */
// ====================================================================
// Single-port program RAM with arbiter
// ====================================================================

`include "fabric_defines.svh"

module shared_ram (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      i_imem_rd,
  input  logic                      i_dmem_rd,
  input  logic                      i_dmem_wr,
  input  logic [`FABRIC_RAM_AW-1:0] i_imem_word,
  input  logic [`FABRIC_RAM_AW-1:0] i_dmem_word,
  input  logic [`FABRIC_XLEN-1:0]   i_dmem_wdata,
  output logic                      o_imem_valid,
  output logic [`FABRIC_XLEN-1:0]   o_imem_data,
  output logic                      o_dmem_valid,
  output logic [`FABRIC_XLEN-1:0]   o_dmem_data
);

  import fabric_pkg::*;

  logic [`FABRIC_XLEN-1:0]   mem [0:`FABRIC_RAM_WORDS-1];
  logic [`FABRIC_XLEN-1:0]   rd_word;
  logic [`FABRIC_RAM_AW-1:0] ram_addr;
  logic                      rd_en;
  ram_grant_t                grant;
  ram_grant_t                grant_q;
  logic                      rd_q;
  logic                      imem_busy;
  logic                      dmem_busy;
  logic                      imem_ret;
  logic                      dmem_ret;

  // ==================================================================
  // Fixed priority: data write, data read, fetch
  // ==================================================================
  always_comb
  begin
    grant    = GRANT_IDLE;
    ram_addr = i_imem_word;
    rd_en    = 1'b0;
    if (i_dmem_wr)
    begin
      grant    = GRANT_DMEM_WR;
      ram_addr = i_dmem_word;
      // Pending read rides along and sees the new word
      rd_en    = i_dmem_rd && !dmem_busy;
    end
    else if (i_dmem_rd && !dmem_busy)
    begin
      grant    = GRANT_DMEM_RD;
      ram_addr = i_dmem_word;
      rd_en    = 1'b1;
    end
    else if (i_imem_rd && !imem_busy)
    begin
      grant = GRANT_IMEM_RD;
      rd_en = 1'b1;
    end
  end

  // Array port, write-first
  always_ff @(posedge clk)
  begin
    if (grant == GRANT_DMEM_WR)
      mem[ram_addr] <= i_dmem_wdata;
    if (rd_en)
      rd_word <= (grant == GRANT_DMEM_WR) ? i_dmem_wdata : mem[ram_addr];
  end

  // Which port the captured word belongs to
  assign imem_ret = rd_q && (grant_q == GRANT_IMEM_RD);
  assign dmem_ret = rd_q && ((grant_q == GRANT_DMEM_RD) || (grant_q == GRANT_DMEM_WR));

  // ==================================================================
  // Grant history, busy flags and result pulses
  // ==================================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      grant_q      <= GRANT_IDLE;
      rd_q         <= 1'b0;
      imem_busy    <= 1'b0;
      dmem_busy    <= 1'b0;
      o_imem_valid <= 1'b0;
      o_dmem_valid <= 1'b0;
    end
    else
    begin
      grant_q      <= grant;
      rd_q         <= rd_en;
      o_imem_valid <= imem_ret;
      o_dmem_valid <= dmem_ret;
      // Busy from grant until the pulse has been shown
      if (o_imem_valid)
        imem_busy <= 1'b0;
      else if (rd_en && (grant == GRANT_IMEM_RD))
        imem_busy <= 1'b1;
      if (o_dmem_valid)
        dmem_busy <= 1'b0;
      else if (rd_en && (grant != GRANT_IMEM_RD))
        dmem_busy <= 1'b1;
    end
  end

  // Per-port result words, held after the pulse
  always_ff @(posedge clk)
  begin
    if (imem_ret)
      o_imem_data <= rd_word;
    if (dmem_ret)
      o_dmem_data <= rd_word;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the memory fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log
( verilator --binary --timing --assert -f build.f --top-module fabric_tb -o fabric_sim &&
  ./obj_dir/fabric_sim ) > run.log 2>&1
! grep -q "test failed" run.log && grep -q "test passed" run.log && echo "PASS" ||
  { echo "FAIL, see run.log"; exit 1; }
